//--- logic/fpRoundCfg.svh
/*
 * Field widths and register map for the binary32 rounding unit.
 * Only IEEE 754 single precision is supported; the datapath assumes
 * a 32-bit word with one sign bit. The register port has a single
 * address bit, so only two registers exist.
 */

`ifndef FP_ROUND_CFG_SVH
`define FP_ROUND_CFG_SVH

// ============================================================
// Floating-point format
// ============================================================
`define FP_EXP_BITS 8
`define FP_FRAC_BITS 23
`define FP_BIAS 127

// ============================================================
// Register addresses
// ============================================================
// Mode register with the output select and saturation enable
`define REG_MODE 1'b0
// Status register with the sticky overflow flag in bit 0
`define REG_STATUS 1'b1

`endif

//--- logic/fpRoundPkg.sv
/*
 * Shared types of the rounding unit.
 * fpWord carries either a binary32 value or a signed integer.
 * Which view is valid depends on the mode at the point of use.
 */

`include "fpRoundCfg.svh"

package fpRoundPkg;

	// Float view of the word, most significant field first
	typedef struct packed {
		logic                     sign;
		logic [`FP_EXP_BITS-1:0]  exponent;
		logic [`FP_FRAC_BITS-1:0] fraction;
	} fpFields;

	// The same 32 bits read as a float or as a two's complement integer
	// The stages write the float view, the converter writes the raw view
	typedef union packed {
		fpFields            fields;
		logic signed [31:0] raw;
	} fpWord;

	// Bit positions in the mode register
	// Set to select the integer result instead of the chopped float
	localparam int MODE_TO_INT = 0;
	// Set to clamp out-of-range conversions instead of wrapping
	localparam int MODE_SAT = 1;

endpackage

//--- logic/fpTrunc.sv
/*
 * Chop stage: clears the fraction bits below the binary point.
 * Magnitudes below one become +0, sign included, and denormals fall
 * in that group. Values already integral, infinity and NaN pass
 * unchanged. One cycle of latency when ce is high.
 */

`timescale 1ns/100ps
`include "fpRoundCfg.svh"

module fpTrunc (
	input  logic              clk,
	input  logic              reset,
	input  logic              ce,
	input  fpRoundPkg::fpWord a,
	output fpRoundPkg::fpWord q
);
	import fpRoundPkg::*;

	// Width of a shift count that can reach the full fraction width
	localparam int SHW = $clog2(`FP_FRAC_BITS + 1);

	localparam logic [`FP_EXP_BITS-1:0] BIAS = `FP_BIAS;
	// Smallest exponent at which every fraction bit is integral
	localparam logic [`FP_EXP_BITS-1:0] INTEGRAL_EXP = `FP_BIAS + `FP_FRAC_BITS;
	localparam logic [SHW-1:0] FRAC_BITS = `FP_FRAC_BITS;

	logic [`FP_EXP_BITS-1:0]  unbiased;
	logic [SHW-1:0]           shamt;
	logic [`FP_FRAC_BITS-1:0] fracMask;
	fpWord                    chopped;

	// ============================================================
	// Mask generation
	// ============================================================
	always_comb begin
		// Only meaningful when the exponent lies in [BIAS, INTEGRAL_EXP)
		unbiased = a.fields.exponent - BIAS;
		// Number of fraction bits that sit below the binary point
		shamt = FRAC_BITS - unbiased[SHW-1:0];
		// Ones over the integral part of the fraction, zeros below it
		// An exponent of exactly BIAS shifts every bit out and leaves 1.0
		fracMask = {`FP_FRAC_BITS{1'b1}} << shamt;
	end

	// ============================================================
	// Chop
	// ============================================================
	always_comb begin
		chopped = a;
		if (a.fields.exponent < BIAS) begin
			// Magnitude below one, result is positive zero
			chopped = '0;
		end else if (a.fields.exponent < INTEGRAL_EXP) begin
			// Sign and exponent are kept, only the fraction is trimmed
			chopped.fields.fraction = a.fields.fraction & fracMask;
		end
		// Otherwise the value is already integral, or it is inf or NaN
	end

	// Output register, held while ce is low
	always_ff @(posedge clk) begin
		if (reset) begin
			q <= '0;
		end else if (ce) begin
			q <= chopped;
		end
	end

endmodule

//--- logic/fpToInt.sv
/*
 * Conversion stage: turns an already chopped binary32 value into a
 * signed 32-bit integer. Fraction bits below the binary point are
 * dropped if present. Out-of-range values, infinity and NaN raise
 * overflow and either wrap to 0x80000000 or clamp when saturate is
 * set. One cycle of latency when ce is high.
 */

`timescale 1ns/100ps
`include "fpRoundCfg.svh"

module fpToInt (
	input  logic              clk,
	input  logic              reset,
	input  logic              ce,
	input  logic              saturate,
	input  fpRoundPkg::fpWord a,
	output fpRoundPkg::fpWord q,
	output logic              overflow
);
	import fpRoundPkg::*;

	// Shifter wide enough for the mantissa moved up by 31 places
	localparam int WIDE = `FP_FRAC_BITS + 32;

	localparam logic [`FP_EXP_BITS-1:0] BIAS = `FP_BIAS;
	// Exponent of 2^31, the first magnitude that does not fit
	localparam logic [`FP_EXP_BITS-1:0] MAX_EXP = `FP_BIAS + 31;
	localparam logic [31:0] INT_MAX = 32'h7FFF_FFFF;
	localparam logic [31:0] INT_MIN = 32'h8000_0000;

	logic                     isSpecial;
	logic                     isNan;
	logic                     belowOne;
	logic                     tooBig;
	logic                     isMinInt;
	logic                     ovf;
	logic [`FP_EXP_BITS-1:0]  unbiased;
	logic [`FP_FRAC_BITS:0]   mant;
	logic [WIDE-1:0]          shifted;
	logic [31:0]              magnitude;
	fpWord                    conv;

	always_comb begin
		// Classify the input
		isSpecial = a.fields.exponent == '1;
		isNan = isSpecial && (a.fields.fraction != '0);
		belowOne = a.fields.exponent < BIAS;
		tooBig = a.fields.exponent >= MAX_EXP;
		// -2^31 is the one value at MAX_EXP that still fits
		isMinInt = a.fields.sign && (a.fields.exponent == MAX_EXP) &&
			(a.fields.fraction == '0);
		ovf = isSpecial || (tooBig && !isMinInt);

		// Hidden one in front of the fraction, then scale by 2^unbiased
		// The binary point sits FP_FRAC_BITS places up in the shifter
		unbiased = a.fields.exponent - BIAS;
		mant = {1'b1, a.fields.fraction};
		shifted = WIDE'(mant) << unbiased[4:0];
		magnitude = shifted[WIDE-1:`FP_FRAC_BITS];

		if (ovf) begin
			// NaN clamps high whatever its sign bit says
			if (saturate && (!a.fields.sign || isNan))
				conv.raw = INT_MAX;
			else
				conv.raw = INT_MIN;
		end else if (belowOne) begin
			conv.raw = '0;
		end else if (isMinInt) begin
			conv.raw = INT_MIN;
		end else begin
			conv.raw = a.fields.sign ? -magnitude : magnitude;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			q <= '0;
			overflow <= 1'b0;
		end else if (ce) begin
			q <= conv;
			overflow <= ovf;
		end
	end

endmodule

//--- logic/fpRoundRegs.sv
/*
 * Mode and status registers behind a four-phase req/ack port.
 * cfgAck follows cfgReq one edge later, and the access happens on
 * the edge that raises cfgAck. Read data holds until the next access.
 * The sticky overflow flag is set by ovfEvent and cleared by writing 1.
 */

`timescale 1ns/100ps
`include "fpRoundCfg.svh"

module fpRoundRegs (
	input  logic        clk,
	input  logic        reset,
	input  logic        cfgReq,
	input  logic        cfgWrite,
	input  logic        cfgAddr,
	input  logic [31:0] cfgWdata,
	output logic        cfgAck,
	output logic [31:0] cfgRdata,
	input  logic        ovfEvent,
	output logic        toInt,
	output logic        saturate
);
	import fpRoundPkg::*;

	logic        access;
	logic        ovfSticky;
	logic [31:0] readData;

	// A new request is one that has not been acknowledged yet
	assign access = cfgReq && !cfgAck;

	// ============================================================
	// Handshake and register state
	// ============================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			cfgAck <= 1'b0;
			toInt <= 1'b0;
			saturate <= 1'b0;
			ovfSticky <= 1'b0;
		end else begin
			// Rises after req is seen high, falls after req is seen low
			cfgAck <= cfgReq;

			if (access && cfgWrite && (cfgAddr == `REG_MODE)) begin
				toInt <= cfgWdata[MODE_TO_INT];
				saturate <= cfgWdata[MODE_SAT];
			end

			// A new overflow beats a clearing write on the same edge
			if (ovfEvent)
				ovfSticky <= 1'b1;
			else if (access && cfgWrite && (cfgAddr == `REG_STATUS) && cfgWdata[0])
				ovfSticky <= 1'b0;
		end
	end

	// Read mux, unused bits read as zero
	always_comb begin
		readData = '0;
		if (cfgAddr == `REG_MODE) begin
			readData[MODE_TO_INT] = toInt;
			readData[MODE_SAT] = saturate;
		end else begin
			readData[0] = ovfSticky;
		end
	end

	// Captured on every access, so a write returns the old contents
	always_ff @(posedge clk) begin
		if (access)
			cfgRdata <= readData;
	end

endmodule

//--- logic/fpRoundUnit.sv
/*
 * Top of the rounding unit: chop stage, integer conversion stage and
 * the control registers. One operation is in flight at a time on a
 * four-phase opReq/opAck port; opAck rises three edges after the
 * edge that captures the operand. The mode must not change while an
 * operation is running.
 */

`timescale 1ns/100ps

module fpRoundUnit (
	input  logic              clk,
	input  logic              reset,
	// Operation port
	input  logic              opReq,
	input  fpRoundPkg::fpWord opData,
	output logic              opAck,
	output fpRoundPkg::fpWord result,
	output logic              resultOverflow,
	// Register port
	input  logic              cfgReq,
	input  logic              cfgWrite,
	input  logic              cfgAddr,
	input  logic [31:0]       cfgWdata,
	output logic              cfgAck,
	output logic [31:0]       cfgRdata
);
	import fpRoundPkg::*;

	// Run count at which the converter output is valid
	localparam logic [1:0] RUN_LAST = 2'd2;

	logic       running;
	logic [1:0] runCount;
	logic       accept;
	logic       finish;
	logic       ce;
	logic       toInt;
	logic       saturate;
	logic       intOverflow;
	logic       ovfGated;
	logic       ovfEvent;
	fpWord      opReg;
	fpWord      truncQ;
	fpWord      intQ;

	// ============================================================
	// Operation sequencer
	// ============================================================
	// Idle means neither running nor holding an ack
	assign accept = opReq && !running && !opAck;
	assign finish = running && (runCount == RUN_LAST);
	// Both stages advance on the first two run cycles
	// The chop stage loads twice from the same operand, which is harmless
	assign ce = running && (runCount != RUN_LAST);

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			runCount <= '0;
			opAck <= 1'b0;
		end else if (accept) begin
			running <= 1'b1;
			runCount <= '0;
		end else if (finish) begin
			running <= 1'b0;
			opAck <= 1'b1;
		end else if (running) begin
			runCount <= runCount + 2'd1;
		end else if (opAck && !opReq) begin
			// Master has released the request, close the cycle
			opAck <= 1'b0;
		end
	end

	// Operand capture on the accepting edge
	always_ff @(posedge clk) begin
		if (accept)
			opReg <= opData;
	end

	// ============================================================
	// Datapath
	// ============================================================
	fpTrunc u_trunc (
		.clk   (clk),
		.reset (reset),
		.ce    (ce),
		.a     (opReg),
		.q     (truncQ)
	);

	fpToInt u_toInt (
		.clk      (clk),
		.reset    (reset),
		.ce       (ce),
		.saturate (saturate),
		.a        (truncQ),
		.q        (intQ),
		.overflow (intOverflow)
	);

	// Overflow only counts when the integer result is the one delivered
	assign ovfGated = toInt && intOverflow;
	// Single pulse per finished operation into the sticky flag
	assign ovfEvent = finish && ovfGated;

	// Result register, held for the whole ack phase
	always_ff @(posedge clk) begin
		if (finish) begin
			result <= toInt ? intQ : truncQ;
			resultOverflow <= ovfGated;
		end
	end

	fpRoundRegs u_regs (
		.clk      (clk),
		.reset    (reset),
		.cfgReq   (cfgReq),
		.cfgWrite (cfgWrite),
		.cfgAddr  (cfgAddr),
		.cfgWdata (cfgWdata),
		.cfgAck   (cfgAck),
		.cfgRdata (cfgRdata),
		.ovfEvent (ovfEvent),
		.toInt    (toInt),
		.saturate (saturate)
	);

endmodule

//--- test/fpRoundUnitAssertions.sv
/*
 * Handshake checks for the rounding unit, bound to its top level.
 * Covers the opReq/opAck order, result stability while opAck is
 * high, and both acks being low right after reset.
 */

`timescale 1ns/100ps

module fpRoundUnitAssertions (
	input logic              clk,
	input logic              reset,
	input logic              opReq,
	input logic              opAck,
	input fpRoundPkg::fpWord result,
	input logic              resultOverflow,
	input logic              cfgAck
);

	// ============================================================
	// Operation port
	// ============================================================
	// An ack only ever answers a request that was raised on the edge that set it
	opAckNeedsReq: assert property (@(posedge clk) disable iff (reset)
		$rose(opAck) |-> $past(opReq))
		else $error("opAck rose while opReq was low");

	// Result and its flag hold for the whole ack phase
	resultHeld: assert property (@(posedge clk) disable iff (reset)
		opAck && $past(opAck) |-> $stable(result) && $stable(resultOverflow))
		else $error("result changed while opAck was high");

	// ============================================================
	// Reset
	// ============================================================
	// One edge of reset is enough to clear both acks
	acksLowAfterReset: assert property (@(posedge clk)
		$past(reset) |-> !opAck && !cfgAck)
		else $error("an ack was high right after reset");

endmodule

//--- test/fpRoundUnitTb.sv
/*
 * Testbench for the rounding unit. Operands are fixed corner values plus
 * a fixed-seed LFSR stream; expected values come from a behavioral model
 * of the chop and conversion rules. Runs stop at the first mismatch.
 * The mode is only changed between operations.
 */

`timescale 1ns/100ps
`include "fpRoundCfg.svh"

module fpRoundUnitTb;
	import fpRoundPkg::*;

	localparam int ACK_TIMEOUT = 50;
	localparam int BURST = 40;
	localparam int NUM_CORNERS = 24;

	// Below one, fractional, integral, inf/NaN and the int32 limits
	localparam logic [31:0] CORNERS [NUM_CORNERS] = '{
		32'h3E80_0000, 32'hBF40_0000, 32'h8000_0000, 32'h0000_0001,
		32'h3F7F_FFFF, 32'h3F80_0000, 32'h3FC0_0000, 32'hC030_0000,
		32'h42F6_E979, 32'h4B18_9680, 32'h4AFF_FFFF, 32'h4B00_0001,
		32'h7F80_0000, 32'hFF80_0000, 32'h7FC0_0000, 32'hFFC0_0001,
		32'h4EFF_FFFF, 32'hCEFF_FFFF, 32'h4F00_0000, 32'hCF00_0000,
		32'hCF00_0001, 32'h4F00_0001, 32'h5015_02F9, 32'hD015_02F9
	};

	logic        clk;
	logic        reset;
	logic        opReq;
	logic        opAck;
	logic        resultOverflow;
	fpWord       opData;
	fpWord       result;
	logic        cfgReq;
	logic        cfgWrite;
	logic        cfgAddr;
	logic        cfgAck;
	logic [31:0] cfgWdata;
	logic [31:0] cfgRdata;

	// Model state kept in step with the DUT registers
	logic [31:0] lfsrState;
	logic        modeToInt;
	logic        modeSat;
	logic        stickyExp;
	int          errorCount;
	logic        opAckSeen = 1'b0;
	logic        cfgAckSeen = 1'b0;

	// Outstanding expectations, oldest first
	fpWord       expResult [$];
	logic        expOvf [$];
	string       opNames [$];
	logic [31:0] expReg [$];
	string       regNames [$];

	fpRoundUnit u_dut (
		.clk            (clk),
		.reset          (reset),
		.opReq          (opReq),
		.opData         (opData),
		.opAck          (opAck),
		.result         (result),
		.resultOverflow (resultOverflow),
		.cfgReq         (cfgReq),
		.cfgWrite       (cfgWrite),
		.cfgAddr        (cfgAddr),
		.cfgWdata       (cfgWdata),
		.cfgAck         (cfgAck),
		.cfgRdata       (cfgRdata)
	);

	bind fpRoundUnit fpRoundUnitAssertions u_assert (
		.clk            (clk),
		.reset          (reset),
		.opReq          (opReq),
		.opAck          (opAck),
		.result         (result),
		.resultOverflow (resultOverflow),
		.cfgAck         (cfgAck)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	// ============================================================
	// Stimulus sources and reference model
	// ============================================================
	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsrStep(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step for every bit handed out
	function automatic logic [31:0] takeBits(int n);
		logic [31:0] w;
		int          i;
		w = '0;
		for (i = 0; i < n; i++) begin
			lfsrState = lfsrStep(lfsrState);
			w = {w[30:0], lfsrState[0]};
		end
		return w;
	endfunction

	// Exponents mostly fall in 110..173 so that both stages see every case
	function automatic fpWord randomOperand();
		fpWord       w;
		logic [31:0] sel;
		logic [31:0] bits;
		sel = takeBits(4);
		if (sel == 32'd0) begin
			w.raw = takeBits(32);
		end else begin
			bits = takeBits(30);
			w.fields.sign = bits[29];
			w.fields.exponent = 8'd110 + {2'b00, bits[28:23]};
			w.fields.fraction = bits[22:0];
		end
		return w;
	endfunction

	// Clears every fraction bit worth less than one
	function automatic fpWord chopRef(fpWord x);
		fpWord r;
		int    e;
		int    i;
		r = x;
		e = int'(x.fields.exponent) - `FP_BIAS;
		if (e < 0) begin
			r = '0;
		end else if (e < `FP_FRAC_BITS) begin
			for (i = 0; i < `FP_FRAC_BITS - e; i++)
				r.fields.fraction[i] = 1'b0;
		end
		return r;
	endfunction

	// Out of int32 range, or inf/NaN, and only counted in integer mode
	function automatic logic refOverflow(fpWord x, logic toInt);
		int e;
		e = int'(x.fields.exponent) - `FP_BIAS;
		if (!toInt)
			return 1'b0;
		if (x.fields.exponent == 8'hFF || e > 31)
			return 1'b1;
		if (e == 31)
			return !(x.fields.sign && x.fields.fraction == '0);
		return 1'b0;
	endfunction

	function automatic fpWord refRound(fpWord operand, logic toInt, logic saturate);
		fpWord  c;
		fpWord  r;
		int     e;
		longint mag;
		logic   isNan;
		c = chopRef(operand);
		e = int'(c.fields.exponent) - `FP_BIAS;
		mag = longint'({1'b1, c.fields.fraction});
		isNan = operand.fields.exponent == 8'hFF && operand.fields.fraction != '0;
		if (!toInt) begin
			r = c;
		end else if (refOverflow(operand, 1'b1)) begin
			// NaN clamps to the positive limit
			if (saturate && (!operand.fields.sign || isNan))
				r.raw = 32'sh7FFF_FFFF;
			else
				r.raw = 32'sh8000_0000;
		end else if (e < 0) begin
			r.raw = '0;
		end else begin
			if (e >= `FP_FRAC_BITS)
				mag = mag << (e - `FP_FRAC_BITS);
			else
				mag = mag >> (`FP_FRAC_BITS - e);
			if (c.fields.sign)
				mag = -mag;
			r.raw = mag[31:0];
		end
		return r;
	endfunction

	function automatic logic [31:0] modeWord();
		logic [31:0] m;
		m = '0;
		m[MODE_TO_INT] = modeToInt;
		m[MODE_SAT] = modeSat;
		return m;
	endfunction

	// ============================================================
	// Checks and bus tasks
	// ============================================================
	task automatic abortRun();
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic checkResult(string name, fpWord expected, fpWord actual);
		if (actual !== expected) begin
			errorCount++;
			$display("ERR %s result expected %08h actual %08h", name, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkFlag(string name, logic expected, logic actual);
		if (actual !== expected) begin
			errorCount++;
			$display("ERR %s overflow expected %0b actual %0b", name, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkReg(string name, logic [31:0] expected, logic [31:0] actual);
		if (actual !== expected) begin
			errorCount++;
			$display("ERR %s register expected %08h actual %08h", name, expected, actual);
			abortRun();
		end
	endtask

	// All bus tasks start and end 1 ns after a rising edge
	task automatic waitOpAck(logic level, string what);
		int n;
		n = 0;
		while (opAck !== level) begin
			@(posedge clk);
			#1;
			n++;
			if (n > ACK_TIMEOUT) begin
				$display("Timeout: opAck never went to %0b during %s", level, what);
				abortRun();
			end
		end
	endtask

	task automatic waitCfgAck(logic level);
		int n;
		n = 0;
		while (cfgAck !== level) begin
			@(posedge clk);
			#1;
			n++;
			if (n > ACK_TIMEOUT) begin
				$display("Timeout: cfgAck never went to %0b on the register port", level);
				abortRun();
			end
		end
	endtask

	task automatic runOp(string name, logic [31:0] value);
		fpWord operand;
		int    hold;
		int    k;
		operand.raw = value;
		// Master back-pressure of zero to three cycles after the ack
		hold = int'(takeBits(2));
		expResult.push_back(refRound(operand, modeToInt, modeSat));
		expOvf.push_back(refOverflow(operand, modeToInt));
		opNames.push_back(name);
		if (refOverflow(operand, modeToInt))
			stickyExp = 1'b1;
		opData = operand;
		opReq = 1'b1;
		waitOpAck(1'b1, name);
		for (k = 0; k < hold; k++) begin
			@(posedge clk);
			#1;
			if (opAck !== 1'b1) begin
				$display("opAck dropped during %s while opReq was still high", name);
				abortRun();
			end
		end
		opReq = 1'b0;
		waitOpAck(1'b0, name);
	endtask

	task automatic writeReg(logic addr, logic [31:0] data);
		cfgAddr = addr;
		cfgWdata = data;
		cfgWrite = 1'b1;
		cfgReq = 1'b1;
		waitCfgAck(1'b1);
		cfgReq = 1'b0;
		waitCfgAck(1'b0);
		if (addr == `REG_MODE) begin
			modeToInt = data[MODE_TO_INT];
			modeSat = data[MODE_SAT];
		end else if (data[0]) begin
			stickyExp = 1'b0;
		end
	endtask

	task automatic readReg(string name, logic addr, logic [31:0] expected);
		expReg.push_back(expected);
		regNames.push_back(name);
		cfgAddr = addr;
		cfgWrite = 1'b0;
		cfgReq = 1'b1;
		waitCfgAck(1'b1);
		cfgReq = 1'b0;
		waitCfgAck(1'b0);
	endtask

	// Compare on the falling edge, half a cycle after the acks rise
	always @(negedge clk) begin
		if (!reset && opAck && !opAckSeen) begin
			if (expResult.size() == 0) begin
				$display("opAck rose with no operation outstanding");
				abortRun();
			end else begin
				checkResult(opNames[0], expResult[0], result);
				checkFlag(opNames[0], expOvf[0], resultOverflow);
				void'(expResult.pop_front());
				void'(expOvf.pop_front());
				void'(opNames.pop_front());
			end
		end
		if (!reset && cfgAck && !cfgAckSeen && !cfgWrite) begin
			if (expReg.size() == 0) begin
				$display("cfgAck rose with no register read outstanding");
				abortRun();
			end else begin
				checkReg(regNames[0], expReg[0], cfgRdata);
				void'(expReg.pop_front());
				void'(regNames.pop_front());
			end
		end
		opAckSeen = opAck;
		cfgAckSeen = cfgAck;
	end

	// ============================================================
	// Test sequence
	// ============================================================
	initial begin
		int          i;
		int          m;
		logic [31:0] mw;
		fpWord       w;
		reset = 1'b1;
		opReq = 1'b0;
		opData = '0;
		cfgReq = 1'b0;
		cfgWrite = 1'b0;
		cfgAddr = 1'b0;
		cfgWdata = '0;
		lfsrState = 32'haf8d0df9;
		modeToInt = 1'b0;
		modeSat = 1'b0;
		stickyExp = 1'b0;
		errorCount = 0;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		readReg("resetMode", `REG_MODE, 32'd0);
		readReg("resetStatus", `REG_STATUS, 32'd0);

		// Float output, overflow never reaches the sticky flag here
		for (i = 0; i < NUM_CORNERS; i++)
			runOp($sformatf("floatCorner%0d", i), CORNERS[i]);
		readReg("floatStatus", `REG_STATUS, 32'd0);

		// Integer output with wrapping on overflow
		mw = '0;
		mw[MODE_TO_INT] = 1'b1;
		writeReg(`REG_MODE, mw);
		readReg("modeInt", `REG_MODE, modeWord());
		for (i = 0; i < NUM_CORNERS; i++)
			runOp($sformatf("intCorner%0d", i), CORNERS[i]);
		readReg("stickySet", `REG_STATUS, {31'd0, stickyExp});
		writeReg(`REG_STATUS, 32'd1);
		readReg("stickyClear", `REG_STATUS, 32'd0);
		runOp("intNoOvf0", 32'h3FC0_0000);
		runOp("intNoOvf1", 32'hC030_0000);
		readReg("stickyHold", `REG_STATUS, 32'd0);

		// Saturating conversion
		mw[MODE_SAT] = 1'b1;
		writeReg(`REG_MODE, mw);
		readReg("modeSat", `REG_MODE, modeWord());
		for (i = 0; i < NUM_CORNERS; i++)
			runOp($sformatf("satCorner%0d", i), CORNERS[i]);
		readReg("satStatus", `REG_STATUS, {31'd0, stickyExp});

		// Random bursts in every mode combination
		for (m = 0; m < 4; m++) begin
			mw = '0;
			mw[MODE_TO_INT] = m[0];
			mw[MODE_SAT] = m[1];
			writeReg(`REG_MODE, mw);
			readReg($sformatf("modeReadback%0d", m), `REG_MODE, modeWord());
			for (i = 0; i < BURST; i++) begin
				w = randomOperand();
				runOp($sformatf("random%0d_%0d", m, i), w.raw);
			end
			readReg($sformatf("burstStatus%0d", m), `REG_STATUS, {31'd0, stickyExp});
			writeReg(`REG_STATUS, 32'd1);
		end

		repeat (2) @(posedge clk);
		if (errorCount == 0 && expResult.size() == 0 && expReg.size() == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- filelist.f
+incdir+logic
logic/fpRoundPkg.sv
logic/fpTrunc.sv
logic/fpToInt.sv
logic/fpRoundRegs.sv
logic/fpRoundUnit.sv
test/fpRoundUnitAssertions.sv
test/fpRoundUnitTb.sv

//--- run.sh
#!/bin/sh
# Builds the rounding unit testbench with Verilator and runs it.
# The outcome is decided by searching the simulation log.

cd "$(dirname "$0")" || exit 1

TOP=fpRoundUnitTb
OBJ=obj_dir
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

# Compile RTL, assertions and testbench into one executable
verilator --binary --timing --assert -Wno-fatal \
	--top-module "$TOP" -Mdir "$OBJ" -f filelist.f
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

"./$OBJ/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	echo "Result: fail"
	exit 1
fi

if grep -F -q '*** TEST PASSED ***' "$LOG"; then
	echo "Result: pass"
	exit 0
fi

echo "Result: fail"
exit 1
